// ==== compile.f ====
+incdir+sim
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx_sampler.sv
hw/uart_receiver.sv
hw/uart_transmitter.sv
hw/uart_top.sv
sim/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - hw/uart_pkg.sv
  - hw/uart_baud_gen.sv
  - hw/uart_rx_sampler.sv
  - hw/uart_receiver.sv
  - hw/uart_transmitter.sv
  - hw/uart_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/uart_tb.sv

// ==== sim/uart_tb_checks.svh ====
// Compare tasks for bytes, flags and serial frames, plus txd frame capture
`ifndef UART_TB_CHECKS_SVH
`define UART_TB_CHECKS_SVH

task automatic check_byte(
    input string                name,
    input logic [DATA_BITS-1:0] actual,
    input logic [DATA_BITS-1:0] expected
);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s expected 8'h%02h, actual 8'h%02h",
                 $time, name, expected, actual);
        fail_run("data byte mismatch");
    end
endtask

task automatic check_flag(
    input string name,
    input logic  actual,
    input logic  expected
);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s expected %b, actual %b",
                 $time, name, expected, actual);
        fail_run("status bit mismatch");
    end
endtask

// Frames shown in binary, start bit rightmost
task automatic check_frame(
    input string              name,
    input logic [FRAME_W-1:0] actual,
    input logic [FRAME_W-1:0] expected
);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s expected %b, actual %b",
                 $time, name, expected, actual);
        fail_run("serial frame mismatch");
    end
endtask

// Finds the start bit, then samples txd at the middle of every bit
task automatic capture_txd_frame(output logic [FRAME_W-1:0] frame);
    int n;
    n = 0;
    while (txd && n < bit_clocks) begin
        next_cycle();
        n++;
    end
    if (txd) begin
        fail_run("no start bit on txd within one bit time");
    end
    wait_clocks(bit_clocks / 2);          // Mid start bit
    for (int i = 0; i < FRAME_W; i++) begin
        frame[i] = txd;
        check_flag("tx_busy", tx_busy, 1'b1);   // Busy through the whole frame
        if (i < FRAME_W - 1) begin
            wait_clocks(bit_clocks);
        end
    end
endtask

`endif

// ==== sim/uart_tb.sv ====
// UART testbench top with clock, reset, DUT, serial line driver, directed tests and timeout
`default_nettype none

module uart_tb import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_FREQ_HZ = 25_000_000;
    localparam int FRAME_W     = DATA_BITS + 3;    // Start, data, parity, stop
    localparam int FAST_BIT    = OVERSAMPLE * baud_divisor(CLK_FREQ_HZ, 3'd7);
    localparam int SLOW_BIT    = OVERSAMPLE * baud_divisor(CLK_FREQ_HZ, 3'd5);
    // Eight frames at select 7 and two at select 5, twice over
    localparam int CYCLE_LIMIT = 2 * FRAME_W * (8 * FAST_BIT + 2 * SLOW_BIT);

    logic                  clk = 1'b0;
    logic                  reset;
    logic [BAUD_SEL_W-1:0] baud_select;
    logic                  rx_en;
    logic                  tx_en;
    logic                  tx_start;
    logic [DATA_BITS-1:0]  tx_data;
    logic                  rxd_drv;       // Line driver output
    logic                  loopback;      // Route txd back to rxd
    logic                  rxd_line;
    logic [DATA_BITS-1:0]  rx_data;
    logic                  rx_valid;
    logic                  rx_ferror;
    logic                  rx_perror;
    logic                  txd;
    logic                  tx_busy;
    logic                  valid_seen;    // Set by monitor, cleared by tests
    int                    bit_clocks;    // Clocks per bit at current select
    int                    cycle_count = 0;

    always #20 clk = ~clk;                // 25 MHz

    assign rxd_line = loopback ? txd : rxd_drv;

    uart_top #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .rx_en       (rx_en),
        .rxd         (rxd_line),
        .tx_en       (tx_en),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_ferror   (rx_ferror),
        .rx_perror   (rx_perror),
        .txd         (txd),
        .tx_busy     (tx_busy)
    );

    // All stimulus and sampling happens 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic fail_run(input string reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    `include "uart_tb_checks.svh"

    // Start bit, data LSB first, even parity (optionally flipped), stop bit
    function automatic logic [FRAME_W-1:0] make_frame(
        input logic [DATA_BITS-1:0] data,
        input logic                 flip_parity,
        input logic                 stop_bit
    );
        logic parity;
        parity = flip_parity;
        for (int i = 0; i < DATA_BITS; i++) begin
            parity = parity ^ data[i];
        end
        return {stop_bit, parity, data, 1'b0};
    endfunction

    function automatic logic [DATA_BITS-1:0] random_byte();
        return DATA_BITS'($urandom_range(2**DATA_BITS - 1, 0));
    endfunction

    // New select reaches the divider at its next reload
    task automatic set_baud(input logic [BAUD_SEL_W-1:0] sel);
        int old_div;
        old_div     = baud_divisor(CLK_FREQ_HZ, baud_select);
        baud_select = sel;
        bit_clocks  = OVERSAMPLE * baud_divisor(CLK_FREQ_HZ, sel);
        wait_clocks(old_div + 1);
    endtask

    // Drives the lowest count bits of a frame, one bit time each
    task automatic send_bits(input logic [FRAME_W-1:0] frame, input int count);
        for (int i = 0; i < count; i++) begin
            rxd_drv = frame[i];
            wait_clocks(bit_clocks);
        end
    endtask

    task automatic wait_rx_valid(input int limit);
        int n;
        n = 0;
        while (!rx_valid && n < limit) begin
            next_cycle();
            n++;
        end
        check_flag("rx_valid", rx_valid, 1'b1);
    endtask

    task automatic reset_values();
        check_flag("rx_valid", rx_valid, 1'b0);
        check_flag("rx_ferror", rx_ferror, 1'b0);
        check_flag("rx_perror", rx_perror, 1'b0);
        check_flag("tx_busy", tx_busy, 1'b0);
        check_flag("txd", txd, 1'b1);
    endtask

    // Good frame, rx_en dropped inside the stop bit
    task automatic receive_good_frame();
        logic [DATA_BITS-1:0] data;
        logic [FRAME_W-1:0]   frame;
        data  = random_byte();
        frame = make_frame(data, 1'b0, 1'b1);
        rx_en = 1'b1;
        wait_clocks(bit_clocks);          // Idle line before start
        send_bits(frame, FRAME_W - 1);
        rxd_drv = frame[FRAME_W-1];
        wait_rx_valid(bit_clocks);        // Must rise inside stop bit
        check_byte("rx_data", rx_data, data);
        check_flag("rx_ferror", rx_ferror, 1'b0);
        check_flag("rx_perror", rx_perror, 1'b0);
        rx_en = 1'b0;
        wait_clocks(bit_clocks);
        check_flag("rx_valid", rx_valid, 1'b0);   // Back in disabled state
    endtask

    task automatic parity_error_lock();
        rx_en = 1'b1;
        wait_clocks(bit_clocks);
        valid_seen = 1'b0;
        send_bits(make_frame(random_byte(), 1'b1, 1'b1), FRAME_W);
        check_flag("rx_perror", rx_perror, 1'b1);
        check_flag("rx_ferror", rx_ferror, 1'b0);
        send_bits(make_frame(random_byte(), 1'b0, 1'b1), FRAME_W);   // Ignored while locked
        check_flag("rx_perror", rx_perror, 1'b1);
        check_flag("rx_valid", valid_seen, 1'b0);
        rx_en = 1'b0;                     // One-clock release pulse
        next_cycle();
        check_flag("rx_perror", rx_perror, 1'b0);
        rx_en = 1'b1;
    endtask

    task automatic framing_error_lock();
        wait_clocks(bit_clocks);
        valid_seen = 1'b0;
        send_bits(make_frame(random_byte(), 1'b0, 1'b0), FRAME_W);   // Stop bit low
        rxd_drv = 1'b1;
        check_flag("rx_ferror", rx_ferror, 1'b1);
        check_flag("rx_perror", rx_perror, 1'b0);
        wait_clocks(bit_clocks);
        check_flag("rx_ferror", rx_ferror, 1'b1);   // Still locked on idle line
        check_flag("rx_valid", valid_seen, 1'b0);
        rx_en = 1'b0;
        next_cycle();
        check_flag("rx_ferror", rx_ferror, 1'b0);
    endtask

    task automatic transmit_frame();
        logic [DATA_BITS-1:0] data;
        logic [FRAME_W-1:0]   captured;
        int                   n;
        data = random_byte();
        check_flag("tx_busy", tx_busy, 1'b0);
        tx_data  = data;
        tx_start = 1'b1;
        next_cycle();
        check_flag("tx_busy", tx_busy, 1'b1);   // One clock after the strobe
        tx_data = ~data;                  // Request while busy, dropped
        next_cycle();
        tx_start = 1'b0;
        capture_txd_frame(captured);
        check_frame("txd", captured, make_frame(data, 1'b0, 1'b1));
        n = 0;
        while (tx_busy && n < bit_clocks) begin
            next_cycle();
            n++;
        end
        check_flag("tx_busy", tx_busy, 1'b0);
        check_flag("txd", txd, 1'b1);
    endtask

    task automatic loopback_frame();
        logic [DATA_BITS-1:0] data;
        data     = random_byte();
        loopback = 1'b1;
        rx_en    = 1'b1;
        wait_clocks(bit_clocks);
        tx_data  = data;
        tx_start = 1'b1;
        next_cycle();
        tx_start = 1'b0;
        wait_rx_valid(FRAME_W * bit_clocks);
        check_byte("rx_data", rx_data, data);
        check_flag("rx_ferror", rx_ferror, 1'b0);
        check_flag("rx_perror", rx_perror, 1'b0);
        rx_en = 1'b0;
        wait_clocks(bit_clocks);          // Transmitter finishes stop bit
        check_flag("tx_busy", tx_busy, 1'b0);
        loopback = 1'b0;
    endtask

    // Valid level seen anywhere, sampled away from the drive point
    always @(negedge clk) begin
        if (rx_valid) begin
            valid_seen = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_run("timeout, tests did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h6968_b059));
        reset       = 1'b1;
        baud_select = 3'd7;
        rx_en       = 1'b0;
        tx_en       = 1'b0;
        tx_start    = 1'b0;
        tx_data     = '0;
        rxd_drv     = 1'b1;               // Idle line
        loopback    = 1'b0;
        valid_seen  = 1'b0;
        bit_clocks  = FAST_BIT;
        wait_clocks(5);
        reset = 1'b0;
        next_cycle();
        reset_values();
        tx_en = 1'b1;                     // Keeps the tick running past rx_en drops
        set_baud(3'd7);
        receive_good_frame();
        receive_good_frame();
        set_baud(3'd5);
        receive_good_frame();
        receive_good_frame();
        set_baud(3'd7);
        parity_error_lock();
        framing_error_lock();
        transmit_frame();
        transmit_frame();
        loopback_frame();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/uart_top.sv ====
// UART top level joining baud generator, input sampler, receiver and transmitter
`default_nettype none

module uart_top import uart_pkg::*; #(
    parameter int CLK_FREQ_HZ = 25_000_000
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [BAUD_SEL_W-1:0] baud_select,  // Shared by both paths
    input  wire                  rx_en,
    input  wire                  rxd,
    input  wire                  tx_en,
    input  wire                  tx_start,
    input  wire [DATA_BITS-1:0]  tx_data,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 rx_ferror,
    output logic                 rx_perror,
    output logic                 txd,
    output logic                 tx_busy
);

    wire  baud_run = rx_en | tx_en;    // Tick runs for either path
    logic os_tick;
    logic rxd_sync;
    logic bit_stable;

    uart_baud_gen #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ)
    ) u_baud_gen (
        .clk         (clk),
        .reset       (reset),
        .baud_select (baud_select),
        .run         (baud_run),
        .os_tick     (os_tick)
    );

    uart_rx_sampler u_rx_sampler (
        .clk        (clk),
        .reset      (reset),
        .enable     (rx_en),
        .rxd        (rxd),
        .os_tick    (os_tick),
        .rxd_sync   (rxd_sync),
        .bit_stable (bit_stable)
    );

    // Receiver sees only the synchronized line
    uart_receiver u_receiver (
        .clk        (clk),
        .reset      (reset),
        .rx_en      (rx_en),
        .rxd        (rxd_sync),
        .os_tick    (os_tick),
        .bit_stable (bit_stable),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ferror  (rx_ferror),
        .rx_perror  (rx_perror)
    );

    uart_transmitter u_transmitter (
        .clk      (clk),
        .reset    (reset),
        .tx_en    (tx_en),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .os_tick  (os_tick),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// ==== hw/uart_transmitter.sv ====
// UART transmitter serializing start, data, even parity and stop bits on the oversample tick
`default_nettype none

module uart_transmitter import uart_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  tx_en,
    input  wire                  tx_start,     // One-clock request
    input  wire [DATA_BITS-1:0]  tx_data,      // Taken with tx_start
    input  wire                  os_tick,      // 16x oversample strobe
    output logic                 txd,
    output logic                 tx_busy
);

    localparam int FRAME_BITS = DATA_BITS + 3;    // Start, data, parity, stop
    localparam int TICK_W     = $clog2(OVERSAMPLE);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(FRAME_BITS - 1);

    logic [FRAME_BITS-1:0] shreg;      // Bit on the line is in LSB
    logic [TICK_W-1:0]     tick_cnt;   // Ticks into current bit
    logic [BIT_W-1:0]      bit_cnt;    // Bits already sent
    logic                  start_ok;   // Accepted request

    // Requests while busy or disabled are dropped
    assign start_ok = tx_start && tx_en && !tx_busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_busy  <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '1;             // Line idles high
        end else if (!tx_en) begin
            // Abort, ticks may stop once the enable is gone
            tx_busy  <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '1;
        end else if (start_ok) begin
            tx_busy  <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= {1'b1, ^tx_data, tx_data, 1'b0};
        end else if (tx_busy && os_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == TICK_LAST) begin
                // Next bit, ones fill from the top
                shreg   <= {1'b1, shreg[FRAME_BITS-1:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == BIT_LAST) begin
                    tx_busy <= 1'b0;    // Stop bit done
                end
            end
        end
    end

    // All ones outside a frame, so the line stays high when idle
    assign txd = shreg[0];

endmodule

`default_nettype wire

// ==== hw/uart_receiver.sv ====
// UART receive FSM with data assembly, parity and framing checks and error lock states
`default_nettype none

module uart_receiver import uart_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  rx_en,
    input  wire                  rxd,          // Synchronized serial input
    input  wire                  os_tick,      // 16x oversample strobe
    input  wire                  bit_stable,   // From sampler
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 rx_ferror,
    output logic                 rx_perror
);

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int IDX_W  = $clog2(DATA_BITS);

    localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(DATA_BITS - 1);

    // Frame states first in frame order, then disabled, idle and the two locks
    localparam logic [2:0] S_START    = 3'd0;
    localparam logic [2:0] S_DATA     = 3'd1;
    localparam logic [2:0] S_PARITY   = 3'd2;
    localparam logic [2:0] S_STOP     = 3'd3;
    localparam logic [2:0] S_DISABLED = 3'd4;
    localparam logic [2:0] S_IDLE     = 3'd5;
    localparam logic [2:0] S_PLOCK    = 3'd6;   // Parity error, held
    localparam logic [2:0] S_FLOCK    = 3'd7;   // Framing error, held

    logic [2:0]        state;
    logic [2:0]        next_state;
    logic [TICK_W-1:0] tick_cnt;     // Ticks into the current bit
    logic [IDX_W-1:0]  bit_idx;      // Next data bit position
    logic              mid_tick;     // Middle of bit
    logic              bit_end;      // Last tick of bit
    logic              stop_window;  // Second half of stop bit or later
    logic              stop_bad;     // Stop bit low or noisy

    assign mid_tick = os_tick && (tick_cnt == TICK_MID);
    assign bit_end  = os_tick && (tick_cnt == TICK_LAST);

    // Stop bit only judged once its middle has passed
    // The history still holds parity samples near the bit edge
    assign stop_window = (state == S_STOP) && (tick_cnt > TICK_MID);
    assign stop_bad    = stop_window && (!rxd || !bit_stable);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_DISABLED;
        end else begin
            state <= next_state;
        end
    end

    // Bit timing counter, restarts on the start edge seen in idle
    // Saturates in stop so a held stop state keeps its check window open
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (state == S_IDLE || state == S_DISABLED) begin
            tick_cnt <= '0;
        end else if (os_tick && !(state == S_STOP && tick_cnt == TICK_LAST)) begin
            tick_cnt <= tick_cnt + 1'b1;        // Wraps at bit end
        end
    end

    // Data bit index, LSB first
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_idx <= '0;
        end else if (state == S_IDLE) begin
            bit_idx <= '0;
        end else if (state == S_DATA && bit_end) begin
            bit_idx <= bit_idx + 1'b1;
        end
    end

    // Received byte, each bit taken at mid-bit
    always_ff @(posedge clk) begin
        if (state == S_DATA && mid_tick) begin
            rx_data[bit_idx] <= rxd;
        end
    end

    // Next state
    // Framing checked ahead of parity in every frame state
    always_comb begin
        next_state = state;
        case (state)
            S_DISABLED: begin
                if (rx_en) begin
                    next_state = S_IDLE;
                end
            end
            S_IDLE: begin
                if (!rx_en) begin
                    next_state = S_DISABLED;
                end else if (!rxd) begin
                    next_state = S_START;       // Falling edge, frame begins
                end
            end
            S_START: begin
                if (mid_tick && !bit_stable) begin
                    next_state = S_FLOCK;
                end else if (bit_end) begin
                    next_state = S_DATA;
                end
            end
            S_DATA: begin
                if (mid_tick && !bit_stable) begin
                    next_state = S_FLOCK;
                end else if (bit_end && bit_idx == IDX_LAST) begin
                    next_state = S_PARITY;
                end
            end
            S_PARITY: begin
                if (mid_tick && !bit_stable) begin
                    next_state = S_FLOCK;
                end else if (mid_tick && (rxd != ^rx_data)) begin
                    next_state = S_PLOCK;       // Even parity mismatch
                end else if (bit_end) begin
                    next_state = S_STOP;
                end
            end
            S_STOP: begin
                if (stop_bad) begin
                    next_state = S_FLOCK;
                end else if (bit_end && !rx_en) begin
                    next_state = S_DISABLED;    // Else hold here with valid up
                end
            end
            S_PLOCK, S_FLOCK: begin
                if (!rx_en) begin
                    next_state = S_DISABLED;    // Only way out besides reset
                end
            end
            default: begin
                next_state = S_DISABLED;
            end
        endcase
    end

    // Flags come from lock states, valid from a clean stop bit
    assign rx_valid  = stop_window && !stop_bad;
    assign rx_ferror = (state == S_FLOCK);
    assign rx_perror = (state == S_PLOCK);

endmodule

`default_nettype wire

// ==== hw/uart_rx_sampler.sv ====
// Serial input synchronizer with oversample history and bit stability flag
`default_nettype none

module uart_rx_sampler import uart_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    input  wire  enable,       // Receiver enable
    input  wire  rxd,          // Raw serial line
    input  wire  os_tick,      // Oversample strobe
    output logic rxd_sync,     // Line after two flops
    output logic bit_stable    // Recent oversamples all agree
);

    logic [1:0]              sync_ff;   // Metastability chain
    logic [STABLE_DEPTH-1:0] history;   // Last values taken on os_tick

    // Two-flop synchronizer, idles at line high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_ff <= '1;
        end else begin
            sync_ff <= {sync_ff[0], rxd};
        end
    end

    assign rxd_sync = sync_ff[1];

    // History shifts once per oversample tick
    // While disabled it is filled with the present level, so the first
    // frame after enable starts from a clean, agreeing history
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            history <= '1;
        end else if (!enable) begin
            history <= {STABLE_DEPTH{rxd_sync}};
        end else if (os_tick) begin
            history <= {history[STABLE_DEPTH-2:0], rxd_sync};  // Newest in LSB
        end
    end

    // Stable when every entry is 1 or every entry is 0
    assign bit_stable = (&history) || !(|history);

endmodule

`default_nettype wire

// ==== hw/uart_baud_gen.sv ====
// Baud tick generator producing the 16x oversample strobe for the selected rate
`default_nettype none

module uart_baud_gen import uart_pkg::*; #(
    parameter int CLK_FREQ_HZ = 25_000_000
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [BAUD_SEL_W-1:0] baud_select,
    input  wire                  run,          // High while either path is enabled
    output logic                 os_tick
);

    logic [15:0] divisor;   // Reload value for current rate
    logic [15:0] count;     // Clocks left until next tick

    // Divisor follows baud_select directly, a change applies at next reload
    assign divisor = baud_divisor(CLK_FREQ_HZ, baud_select);

    // Down-counter
    // 0 means cleared, so the first enabled clock only loads the divisor
    // Tick fires at count 1, then reload, giving one tick per divisor clocks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;                // Held clear while both paths are off
        end else if (count <= 16'd1) begin
            count <= divisor;           // Load after clear or after a tick
        end else begin
            count <= count - 16'd1;
        end
    end

    // One-clock pulse at the end of each period
    assign os_tick = run && (count == 16'd1);

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
// UART package: frame constants, baud rate table and baud divisor function
`default_nettype none

package uart_pkg;

    // Frame format, 8 data bits with even parity and one stop bit
    localparam int DATA_BITS    = 8;    // Data bits per frame
    localparam int OVERSAMPLE   = 16;   // Ticks per bit
    localparam int BAUD_SEL_W   = 3;    // Width of baud_select
    localparam int STABLE_DEPTH = 3;    // Oversamples that must agree

    // Rates indexed by baud_select
    localparam int BAUD_RATES [2**BAUD_SEL_W] = '{
        300,
        1200,
        4800,
        9600,
        19200,
        38400,
        57600,
        115200
    };

    // Clocks per oversample tick, never below 1
    function automatic logic [15:0] baud_divisor(
        input int                    clk_freq_hz,
        input logic [BAUD_SEL_W-1:0] sel
    );
        int div;
        div = clk_freq_hz / (BAUD_RATES[sel] * OVERSAMPLE);
        if (div < 1) begin
            div = 1;                    // Clock too slow for the rate
        end
        return div[15:0];
    endfunction

endpackage

`default_nettype wire
